/* lz77_match_search.sv */
// execute stage of the lz77 compressor: grows match lengths per cycle and picks the best distance
`timescale 1ns/1ns

module lz77_match_search import lz77_pkg::*; (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             sch_start_i,
  input  logic [WIN_SIZE-1:0][DATA_WD-1:0] win_dat_i,
  input  logic [DST_WD-1:0]                win_fill_i,
  input  logic [LEN_MAX-1:0][DATA_WD-1:0]  inp_dat_i,
  input  logic [LEN_WD-1:0]                inp_fill_i,
  output logic                             sch_done_o,
  output logic [LEN_WD-1:0]                best_len_o,
  output logic [DST_WD-1:0]                best_dst_o
);

  logic                busy_r;
  logic [LEN_WD-1:0]   step_r;
  logic [WIN_SIZE-1:0] flg_r;
  logic [WIN_SIZE-1:0] flg_init_w;
  logic [WIN_SIZE-1:0] flg_nxt_w;
  logic [LEN_WD-1:0]   best_len_r;
  logic [DST_WD-1:0]   best_dst_r;
  logic [DST_WD-1:0]   prio_dst_w;
  logic                any_w;
  logic                stop_w;

  // ----------------------------------------
  // match flags, bit i is distance i+1
  // ----------------------------------------

  // distances past the window fill never take part
  always_comb begin
    for (int i = 0; i < WIN_SIZE; i++) begin
      flg_init_w[i] = (i < win_fill_i);
    end
  end

  // step k compares lookahead byte k with the byte d positions earlier,
  // which sits in the window at distance d-k while d > k
  always_comb begin
    for (int i = 0; i < WIN_SIZE; i++) begin
      if (i < step_r) begin
        flg_nxt_w[i] = 1'b0;
      end else begin
        flg_nxt_w[i] = flg_r[i] && (inp_dat_i[step_r] == win_dat_i[i - step_r]);
      end
    end
  end

  assign any_w = |flg_nxt_w;

  // smallest surviving distance wins
  always_comb begin
    prio_dst_w = '0;
    for (int i = WIN_SIZE - 1; i >= 0; i--) begin
      if (flg_nxt_w[i]) begin
        prio_dst_w = DST_WD'(i + 1);
      end
    end
  end

  // ----------------------------------------
  // step control
  // ----------------------------------------

  assign stop_w     = !any_w || (step_r + LEN_WD'(1) == inp_fill_i);
  assign sch_done_o = busy_r && stop_w;

  // result of the current step if it still has a survivor
  assign best_len_o = any_w ? step_r + LEN_WD'(1) : best_len_r;
  assign best_dst_o = any_w ? prio_dst_w : best_dst_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_r     <= 1'b0;
      step_r     <= '0;
      flg_r      <= '0;
      best_len_r <= '0;
      best_dst_r <= '0;
    end else if (sch_start_i) begin
      busy_r     <= 1'b1;
      step_r     <= '0;
      flg_r      <= flg_init_w;
      best_len_r <= '0;
      best_dst_r <= '0;
    end else if (busy_r) begin
      if (stop_w) begin
        busy_r <= 1'b0;
      end
      step_r <= step_r + 1'b1;
      flg_r  <= flg_nxt_w;
      if (any_w) begin
        best_len_r <= step_r + LEN_WD'(1);
        best_dst_r <= prio_dst_w;
      end
    end
  end

endmodule

/* lz77_pkg.sv */
// shared sizes, widths and the controller state type for the lz77 compressor, imported by all rtl
package lz77_pkg;

  // ----------------------------------------
  // symbol and window sizes
  // ----------------------------------------

  // one input symbol
  localparam int DATA_WD = 8;

  // sliding window depth
  localparam int WIN_SIZE = 16;

  // distances run 1..WIN_SIZE, so one extra bit
  localparam int DST_WD = 5;

  // ----------------------------------------
  // match lengths
  // ----------------------------------------

  // longest match, also the lookahead depth
  localparam int LEN_MAX = 8;

  // shorter results go out as literals
  localparam int LEN_MIN = 3;

  // lengths 0..LEN_MAX
  localparam int LEN_WD = 4;

  // ----------------------------------------
  // block accounting
  // ----------------------------------------

  // block length and byte counters, blocks of 1 to 255 bytes
  localparam int BLK_LEN_WD = 8;

  // ----------------------------------------
  // block controller states
  // ----------------------------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // waiting for start
    ST_UPT  = 2'd1,  // fetch into lookahead, shift window
    ST_SCH  = 2'd2   // search in progress
  } state_e;

endpackage

/* lz77_token_out.sv */
// result stage of the lz77 compressor: forms literal or match tokens and tracks block end
`timescale 1ns/1ns

module lz77_token_out import lz77_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_i,
  input  logic [BLK_LEN_WD-1:0] cfg_len_i,
  input  logic                  sch_done_i,
  input  logic [LEN_WD-1:0]     best_len_i,
  input  logic [DST_WD-1:0]     best_dst_i,
  input  logic [DATA_WD-1:0]    inp_first_i,
  output logic                  val_o,
  output logic                  flg_lit_o,
  output logic [DATA_WD-1:0]    dat_lit_o,
  output logic [LEN_WD-1:0]     dat_len_o,
  output logic [DST_WD-1:0]     dat_dst_o,
  output logic                  flg_lst_o,
  output logic                  done_o,
  output logic                  tok_pulse_o,
  output logic [LEN_WD-1:0]     adv_len_o,
  output logic                  blk_end_o
);

  logic                  run_r;
  logic [BLK_LEN_WD-1:0] blk_len_r;
  logic [BLK_LEN_WD-1:0] emit_cnt_r;
  logic [BLK_LEN_WD-1:0] cnt_nxt_w;
  logic                  val_r;
  logic                  done_r;
  logic                  blk_end_r;
  logic                  lit_r;
  logic [DATA_WD-1:0]    lit_dat_r;
  logic [LEN_WD-1:0]     len_r;
  logic [DST_WD-1:0]     dst_r;
  logic                  start_acc_w;
  logic                  lit_w;
  logic [LEN_WD-1:0]     adv_w;

  // ----------------------------------------
  // token decision
  // ----------------------------------------

  assign start_acc_w = start_i && !run_r;
  assign lit_w       = best_len_i < LEN_WD'(LEN_MIN);
  assign adv_w       = lit_w ? LEN_WD'(1) : best_len_i;
  assign cnt_nxt_w   = emit_cnt_r + BLK_LEN_WD'(adv_w);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      run_r      <= 1'b0;
      blk_len_r  <= '0;
      emit_cnt_r <= '0;
      blk_end_r  <= 1'b0;
    end else if (start_acc_w) begin
      run_r      <= 1'b1;
      blk_len_r  <= cfg_len_i;
      emit_cnt_r <= '0;
      blk_end_r  <= 1'b0;
    end else begin
      if (sch_done_i) begin
        emit_cnt_r <= cnt_nxt_w;
        if (cnt_nxt_w == blk_len_r) begin
          blk_end_r <= 1'b1;
        end
      end
      // block closes with its last token
      if (val_r && blk_end_r) begin
        run_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_r  <= 1'b0;
      done_r <= 1'b0;
    end else begin
      val_r  <= sch_done_i;
      done_r <= val_r && blk_end_r;
    end
  end

  // token fields, a literal carries no distance
  always_ff @(posedge clk) begin
    if (sch_done_i) begin
      lit_r     <= lit_w;
      lit_dat_r <= inp_first_i;
      len_r     <= adv_w;
      dst_r     <= lit_w ? '0 : best_dst_i;
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  assign val_o       = val_r;
  assign flg_lit_o   = val_r && lit_r;
  assign dat_lit_o   = (val_r && lit_r) ? lit_dat_r : '0;
  assign dat_len_o   = val_r ? len_r : '0;
  assign dat_dst_o   = val_r ? dst_r : '0;
  assign flg_lst_o   = val_r && blk_end_r;
  assign done_o      = done_r;
  assign tok_pulse_o = val_r;
  assign adv_len_o   = len_r;
  assign blk_end_o   = blk_end_r;

endmodule

/* lz77_top.sv */
// top level of the lz77 byte-stream compressor, connects the window, search and token stages
`timescale 1ns/1ns

module lz77_top import lz77_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_i,
  input  logic [BLK_LEN_WD-1:0] cfg_len_i,
  input  logic [DATA_WD-1:0]    rd_dat_i,
  output logic                  rd_val_o,
  output logic                  val_o,
  output logic                  flg_lit_o,
  output logic [DATA_WD-1:0]    dat_lit_o,
  output logic [LEN_WD-1:0]     dat_len_o,
  output logic [DST_WD-1:0]     dat_dst_o,
  output logic                  flg_lst_o,
  output logic                  done_o
);

  // window to search
  logic                             sch_start;
  logic [WIN_SIZE-1:0][DATA_WD-1:0] win_dat;
  logic [DST_WD-1:0]                win_fill;
  logic [LEN_MAX-1:0][DATA_WD-1:0]  inp_dat;
  logic [LEN_WD-1:0]                inp_fill;

  // search to token
  logic                             sch_done;
  logic [LEN_WD-1:0]                best_len;
  logic [DST_WD-1:0]                best_dst;

  // token back to window
  logic                             tok_pulse;
  logic [LEN_WD-1:0]                adv_len;
  logic                             blk_end;

  lz77_window u_window (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .rd_dat_i    (rd_dat_i),
    .tok_pulse_i (tok_pulse),
    .adv_len_i   (adv_len),
    .blk_end_i   (blk_end),
    .rd_val_o    (rd_val_o),
    .sch_start_o (sch_start),
    .win_dat_o   (win_dat),
    .win_fill_o  (win_fill),
    .inp_dat_o   (inp_dat),
    .inp_fill_o  (inp_fill)
  );

  lz77_match_search u_match_search (
    .clk         (clk),
    .rstn        (rstn),
    .sch_start_i (sch_start),
    .win_dat_i   (win_dat),
    .win_fill_i  (win_fill),
    .inp_dat_i   (inp_dat),
    .inp_fill_i  (inp_fill),
    .sch_done_o  (sch_done),
    .best_len_o  (best_len),
    .best_dst_o  (best_dst)
  );

  lz77_token_out u_token_out (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .sch_done_i  (sch_done),
    .best_len_i  (best_len),
    .best_dst_i  (best_dst),
    .inp_first_i (inp_dat[0]),
    .val_o       (val_o),
    .flg_lit_o   (flg_lit_o),
    .dat_lit_o   (dat_lit_o),
    .dat_len_o   (dat_len_o),
    .dat_dst_o   (dat_dst_o),
    .flg_lst_o   (flg_lst_o),
    .done_o      (done_o),
    .tok_pulse_o (tok_pulse),
    .adv_len_o   (adv_len),
    .blk_end_o   (blk_end)
  );

endmodule

/* lz77_window.sv */
// decode stage of the lz77 compressor: block FSM, byte fetch into the lookahead, window shift
`timescale 1ns/1ns

module lz77_window import lz77_pkg::*; (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             start_i,
  input  logic [BLK_LEN_WD-1:0]            cfg_len_i,
  input  logic [DATA_WD-1:0]               rd_dat_i,
  input  logic                             tok_pulse_i,
  input  logic [LEN_WD-1:0]                adv_len_i,
  input  logic                             blk_end_i,
  output logic                             rd_val_o,
  output logic                             sch_start_o,
  output logic [WIN_SIZE-1:0][DATA_WD-1:0] win_dat_o,
  output logic [DST_WD-1:0]                win_fill_o,
  output logic [LEN_MAX-1:0][DATA_WD-1:0]  inp_dat_o,
  output logic [LEN_WD-1:0]                inp_fill_o
);

  state_e                           cur_state_r;
  state_e                           nxt_state_w;
  logic [BLK_LEN_WD-1:0]            blk_len_r;
  logic [BLK_LEN_WD-1:0]            fet_cnt_r;
  logic [LEN_WD-1:0]                inp_fill_r;
  logic [DST_WD-1:0]                win_fill_r;
  logic [DST_WD-1:0]                win_sum_w;
  logic [WIN_SIZE-1:0][DATA_WD-1:0] win_dat_r;
  logic [WIN_SIZE-1:0][DATA_WD-1:0] win_shf_w;
  logic [LEN_MAX-1:0][DATA_WD-1:0]  inp_dat_r;
  logic [LEN_MAX-1:0][DATA_WD-1:0]  inp_shf_w;
  logic                             start_acc_w;
  logic                             more_w;
  logic                             shift_w;

  // ----------------------------------------
  // block FSM
  // ----------------------------------------

  assign start_acc_w = (cur_state_r == ST_IDLE) && start_i;
  // lookahead not full and block input not exhausted
  assign more_w      = (inp_fill_r < LEN_WD'(LEN_MAX)) && (fet_cnt_r < blk_len_r);
  assign rd_val_o    = (cur_state_r == ST_UPT) && more_w;
  assign sch_start_o = (cur_state_r == ST_UPT) && !more_w;
  assign shift_w     = (cur_state_r == ST_SCH) && tok_pulse_i;

  always_comb begin
    nxt_state_w = cur_state_r;
    case (cur_state_r)
      ST_IDLE: if (start_i) nxt_state_w = ST_UPT;
      ST_UPT:  if (!more_w) nxt_state_w = ST_SCH;
      ST_SCH:  if (tok_pulse_i) nxt_state_w = blk_end_i ? ST_IDLE : ST_UPT;
      default: nxt_state_w = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cur_state_r <= ST_IDLE;
    end else begin
      cur_state_r <= nxt_state_w;
    end
  end

  // ----------------------------------------
  // fill counters
  // ----------------------------------------

  assign win_sum_w = win_fill_r + DST_WD'(adv_len_i);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      blk_len_r  <= '0;
      fet_cnt_r  <= '0;
      inp_fill_r <= '0;
      win_fill_r <= '0;
    end else if (start_acc_w) begin
      blk_len_r  <= cfg_len_i;
      fet_cnt_r  <= '0;
      inp_fill_r <= '0;
      win_fill_r <= '0;
    end else if (rd_val_o) begin
      fet_cnt_r  <= fet_cnt_r + 1'b1;
      inp_fill_r <= inp_fill_r + 1'b1;
    end else if (shift_w) begin
      inp_fill_r <= inp_fill_r - adv_len_i;
      // window saturates once full
      win_fill_r <= (win_sum_w > DST_WD'(WIN_SIZE)) ? DST_WD'(WIN_SIZE) : win_sum_w;
    end
  end

  // ----------------------------------------
  // window and lookahead shift
  // ----------------------------------------

  // index 0 of the window is the most recent byte, distance 1
  always_comb begin
    for (int j = 0; j < WIN_SIZE; j++) begin
      if (j < adv_len_i) begin
        win_shf_w[j] = inp_dat_r[adv_len_i - 1 - j];
      end else begin
        win_shf_w[j] = win_dat_r[j - adv_len_i];
      end
    end
  end

  always_comb begin
    for (int j = 0; j < LEN_MAX; j++) begin
      if (j + adv_len_i < LEN_MAX) begin
        inp_shf_w[j] = inp_dat_r[j + adv_len_i];
      end else begin
        inp_shf_w[j] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_acc_w) begin
      win_dat_r <= '0;
      inp_dat_r <= '0;
    end else if (rd_val_o) begin
      inp_dat_r[inp_fill_r] <= rd_dat_i;
    end else if (shift_w) begin
      win_dat_r <= win_shf_w;
      inp_dat_r <= inp_shf_w;
    end
  end

  assign win_dat_o  = win_dat_r;
  assign win_fill_o = win_fill_r;
  assign inp_dat_o  = inp_dat_r;
  assign inp_fill_o = inp_fill_r;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the lz77 testbench with verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lz77_top -f src.f \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation run returned an error"
  exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  echo "pass line not found in sim.log"
  exit 1
fi

/* src.f */
lz77_pkg.sv
lz77_window.sv
lz77_match_search.sv
lz77_token_out.sv
lz77_top.sv
tb_lz77_top.sv

/* tb_lz77_top.sv */
// self-checking testbench for the lz77 compressor, runs a table of blocks against a greedy model
`timescale 1ns/1ns

module tb_lz77_top import lz77_pkg::*; ();

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------

  localparam int NUM_ROWS  = 11;
  localparam int PAT_DIST  = 0;
  localparam int PAT_REP   = 1;
  localparam int PAT_CONST = 2;
  localparam int PAT_RAND  = 3;
  localparam int PAT_PREV  = 4;

  // block length, pattern, pattern argument, expected token count (0 means model only)
  // rep takes the period as argument, rand takes the alphabet size
  localparam int TBL_LEN [NUM_ROWS] = '{1, 12, 10, 20, 24, 30, 40, 40, 200, 255, 255};
  localparam int TBL_PAT [NUM_ROWS] = '{PAT_DIST, PAT_DIST, PAT_REP, PAT_CONST, PAT_REP,
                                        PAT_REP, PAT_REP, PAT_PREV, PAT_RAND, PAT_RAND,
                                        PAT_DIST};
  localparam int TBL_ARG [NUM_ROWS] = '{0, 0, 1, 0, 2, 3, 4, 0, 4, 2, 0};
  localparam int TBL_CNT [NUM_ROWS] = '{1, 12, 5, 6, 7, 9, 9, 9, 0, 0, 255};

  logic                  clk;
  logic                  rstn;
  logic                  start_i;
  logic [BLK_LEN_WD-1:0] cfg_len_i;
  logic [DATA_WD-1:0]    rd_dat_i;
  logic                  rd_val_o;
  logic                  val_o;
  logic                  flg_lit_o;
  logic [DATA_WD-1:0]    dat_lit_o;
  logic [LEN_WD-1:0]     dat_len_o;
  logic [DST_WD-1:0]     dat_dst_o;
  logic                  flg_lst_o;
  logic                  done_o;

  // current block bytes and fifo read pointer
  logic [DATA_WD-1:0] blk_dat [256];
  int                 rd_idx;

  // expected tokens from the reference model
  logic               exp_lit  [256];
  logic [DATA_WD-1:0] exp_byte [256];
  int                 exp_len  [256];
  int                 exp_dst  [256];
  int                 exp_n;

  int err_cnt;
  int chk_cnt;

  lz77_top DUT (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_len_i (cfg_len_i),
    .rd_dat_i  (rd_dat_i),
    .rd_val_o  (rd_val_o),
    .val_o     (val_o),
    .flg_lit_o (flg_lit_o),
    .dat_lit_o (dat_lit_o),
    .dat_len_o (dat_len_o),
    .dat_dst_o (dat_dst_o),
    .flg_lst_o (flg_lst_o),
    .done_o    (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic fill_block(input int pat, input int arg, input int len);
    for (int i = 0; i < len; i++) begin
      case (pat)
        PAT_DIST:  blk_dat[i] = DATA_WD'(i * 7 + 3);
        PAT_REP:   blk_dat[i] = DATA_WD'(8'h30 + i % arg);
        PAT_CONST: blk_dat[i] = 8'ha5;
        PAT_RAND:  blk_dat[i] = DATA_WD'(8'h41 + $urandom % arg);
        // previous block's bytes stay in place
        default: ;
      endcase
    end
  endtask

  // greedy rule, longest non-overlapping match, ties to the smallest distance
  task automatic build_expected(input int len);
    int pos;
    int lim;
    int l;
    int best_l;
    int best_d;
    pos   = 0;
    exp_n = 0;
    while (pos < len) begin
      best_l = 0;
      best_d = 0;
      lim    = (pos < WIN_SIZE) ? pos : WIN_SIZE;
      for (int d = 1; d <= lim; d++) begin
        l = 0;
        while (l < LEN_MAX && l < len - pos && l < d &&
               blk_dat[pos + l] == blk_dat[pos + l - d]) begin
          l++;
        end
        if (l > best_l) begin
          best_l = l;
          best_d = d;
        end
      end
      if (best_l < LEN_MIN) begin
        exp_lit[exp_n]  = 1'b1;
        exp_byte[exp_n] = blk_dat[pos];
        exp_len[exp_n]  = 1;
        exp_dst[exp_n]  = 0;
        pos++;
      end else begin
        exp_lit[exp_n]  = 1'b0;
        exp_byte[exp_n] = '0;
        exp_len[exp_n]  = best_l;
        exp_dst[exp_n]  = best_d;
        pos += best_l;
      end
      exp_n++;
    end
  endtask

  task automatic run_block(input int row);
    int   tok_idx;
    int   len_sum;
    logic seen_last;
    fill_block(TBL_PAT[row], TBL_ARG[row], TBL_LEN[row]);
    build_expected(TBL_LEN[row]);
    @(posedge clk);
    #10;
    rd_idx    = 0;
    rd_dat_i  = blk_dat[0];
    cfg_len_i = BLK_LEN_WD'(TBL_LEN[row]);
    start_i   = 1'b1;
    @(posedge clk);
    #10;
    start_i   = 1'b0;
    tok_idx   = 0;
    len_sum   = 0;
    seen_last = 1'b0;
    while (!seen_last) begin
      @(negedge clk);
      check_val(done_o, 0, "done_o before the last token");
      if (val_o) begin
        if (tok_idx < exp_n) begin
          check_val(flg_lit_o, exp_lit[tok_idx], "flg_lit_o");
          check_val(dat_lit_o, exp_byte[tok_idx], "dat_lit_o");
          check_val(dat_len_o, exp_len[tok_idx], "dat_len_o");
          check_val(dat_dst_o, exp_dst[tok_idx], "dat_dst_o");
          check_val(flg_lst_o, tok_idx == exp_n - 1, "flg_lst_o");
        end else begin
          err_cnt++;
          $display("block %0d gave more tokens than the reference model", row);
        end
        // a cleared window cannot start with a match
        if (tok_idx == 0 && TBL_PAT[row] == PAT_PREV) begin
          check_val(flg_lit_o, 1, "first token of a repeated block");
        end
        len_sum += int'(dat_len_o);
        tok_idx++;
        seen_last = flg_lst_o;
      end else begin
        check_val({flg_lst_o, flg_lit_o, dat_lit_o, dat_len_o, dat_dst_o}, '0,
                  "token fields while val_o is low");
      end
    end
    @(negedge clk);
    check_val(done_o, 1, "done_o after the last token");
    check_val(val_o, 0, "val_o after the last token");
    check_val(tok_idx, exp_n, "token count against model");
    if (TBL_CNT[row] != 0) begin
      check_val(tok_idx, TBL_CNT[row], "token count against table");
    end
    check_val(len_sum, TBL_LEN[row], "sum of token lengths");
    check_val(rd_idx, TBL_LEN[row], "fifo reads");
    repeat (3) begin
      @(negedge clk);
      check_val({val_o, rd_val_o, done_o}, '0, "outputs between blocks");
    end
  endtask

  // ----------------------------------------
  // fifo model and watchdog
  // ----------------------------------------

  // fwft, next byte shows up once the current one is consumed
  initial begin : fifo_model
    logic take;
    forever begin
      @(negedge clk);
      take = rd_val_o;
      @(posedge clk);
      #10;
      if (take) begin
        rd_idx++;
        rd_dat_i = (rd_idx < 256) ? blk_dat[rd_idx] : '0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    int cyc;
    limit = 0;
    cyc   = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += TBL_LEN[r] * (LEN_MAX + 4) + 100;
    end
    while (cyc < limit) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: the blocks did not finish within %0d clock cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin : main_seq
    int rnd_seed;
    rnd_seed  = $urandom(32'hff59_ddb4);
    err_cnt   = 0;
    chk_cnt   = 0;
    rd_idx    = 0;
    rstn      = 1'b0;
    start_i   = 1'b0;
    cfg_len_i = '0;
    rd_dat_i  = '0;
    repeat (5) @(posedge clk);
    #10;
    rstn = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_val({val_o, rd_val_o, done_o, flg_lst_o}, '0, "outputs after reset");
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_block(r);
    end
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
